/* source/duck_hunt_pkg.sv */
// shared constants for the duck hunt display
// screen geometry, sprite sizes, hud layout, colours and state enums

package duck_hunt_pkg;

	// 640x480 timing, sync positions in pixel/line counts
	localparam int h_visible    = 640;
	localparam int v_visible    = 480;
	localparam int h_total      = 800;
	localparam int v_total      = 525;
	localparam int h_sync_start = 656;
	localparam int h_sync_end   = 752;
	localparam int v_sync_start = 490;
	localparam int v_sync_end   = 492;
	localparam int coord_w      = 10;

	// duck sprite: 8x8 cells, each cell drawn 4x4
	localparam int sprite_px    = 8;
	localparam int sprite_scale = 4;
	localparam int duck_size    = 32;
	localparam int hit_margin   = 6;

	// cursor and shot flash
	localparam int cursor_size = 6;
	localparam int flash_half  = 25;

	// bullet squares in the lower hud
	localparam int bullet_x0    = 68;
	localparam int bullet_pitch = 17;
	localparam int bullet_w     = 9;
	localparam int bullet_y0    = 418;
	localparam int bullet_h     = 13;
	localparam int max_shots    = 3;

	// start button on the menu screen
	localparam int start_x0 = 200;
	localparam int start_x1 = 440;
	localparam int start_y0 = 200;
	localparam int start_y1 = 250;

	localparam logic [11:0] white_rgb  = 12'hFFF;
	localparam logic [11:0] bullet_rgb = 12'hAAA;
	localparam logic [11:0] menu_rgb   = 12'h024;
	localparam logic [11:0] button_rgb = 12'hF80;
	localparam logic [11:0] sky_rgb    = 12'h6AF;
	localparam logic [11:0] black_rgb  = 12'h000;

	localparam int transparent_index = 0;

	typedef enum logic {state_menu, state_play} game_state_e;

	// value 3 is unused and shown with the black palette
	typedef enum logic [1:0] {duck_black, duck_red, duck_pink} duck_color_e;

endpackage

/* source/vga_controller.sv */
// vga timing generator
// pixel and line counters, registered draw coordinates, blank and syncs

`timescale 1ns/1ps

module vga_controller (
	input  logic                               vga_clk,
	input  logic                               Reset,
	output logic [duck_hunt_pkg::coord_w-1:0] draw_x,
	output logic [duck_hunt_pkg::coord_w-1:0] draw_y,
	output logic                               blank,
	output logic                               hsync,
	output logic                               vsync
);

	logic [duck_hunt_pkg::coord_w-1:0] h_cnt;
	logic [duck_hunt_pkg::coord_w-1:0] v_cnt;
	logic                              h_last;

	assign h_last = (h_cnt == duck_hunt_pkg::h_total - 1);

	// free running counters, one pixel per clock
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			h_cnt <= '0;
			v_cnt <= '0;
		end
		else
		begin
			if (h_last)
			begin
				h_cnt <= '0;
				if (v_cnt == duck_hunt_pkg::v_total - 1)
					v_cnt <= '0;
				else
					v_cnt <= v_cnt + 1'b1;
			end
			else
				h_cnt <= h_cnt + 1'b1;
		end
	end

	// decoded outputs registered together with the coordinates
	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			draw_x <= '0;
			draw_y <= '0;
			blank  <= 1'b0;
			hsync  <= 1'b1;
			vsync  <= 1'b1;
		end
		else
		begin
			draw_x <= h_cnt;
			draw_y <= v_cnt;
			blank  <= (h_cnt < duck_hunt_pkg::h_visible) && (v_cnt < duck_hunt_pkg::v_visible);
			hsync  <= !((h_cnt >= duck_hunt_pkg::h_sync_start) &&
				(h_cnt < duck_hunt_pkg::h_sync_end));
			vsync  <= !((v_cnt >= duck_hunt_pkg::v_sync_start) &&
				(v_cnt < duck_hunt_pkg::v_sync_end));
		end
	end

endmodule

/* source/shot_control.sv */
// shot controller
// trigger edge detect, flash timer, bullets fired, duck hit test, menu/play state

`timescale 1ns/1ps

module shot_control #(
	parameter int shot_flash_cycles = 1_000_000
) (
	input  logic                               vga_clk,
	input  logic                               Reset,
	input  logic [duck_hunt_pkg::coord_w-1:0] cursor_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] cursor_y,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_y,
	input  logic                               duck_present,
	input  logic                               trigger,
	output logic                               shot_on,
	output logic [1:0]                         shots_fired,
	output duck_hunt_pkg::game_state_e         game_state,
	output logic                               duck_kill,
	output logic                               game_start
);

	localparam int cnt_w = $clog2(shot_flash_cycles + 1);

	logic             trig_s;
	logic             trig_d;
	logic             trig_rise;
	logic             in_start;
	logic             in_hit_box;
	logic             kill_q;
	logic [cnt_w-1:0] flash_cnt;

	assign trig_rise = trig_s && !trig_d;

	assign in_start = (cursor_x >= duck_hunt_pkg::start_x0) && (cursor_x < duck_hunt_pkg::start_x1) &&
		(cursor_y >= duck_hunt_pkg::start_y0) && (cursor_y < duck_hunt_pkg::start_y1);

	// strictly inside the duck square with the margin taken off each side
	assign in_hit_box = (cursor_x > duck_x + duck_hunt_pkg::hit_margin) &&
		(cursor_x < duck_x + duck_hunt_pkg::duck_size - duck_hunt_pkg::hit_margin) &&
		(cursor_y > duck_y + duck_hunt_pkg::hit_margin) &&
		(cursor_y < duck_y + duck_hunt_pkg::duck_size - duck_hunt_pkg::hit_margin);

	assign duck_kill = shot_on && duck_present && in_hit_box;

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			trig_s      <= 1'b0;
			trig_d      <= 1'b0;
			kill_q      <= 1'b0;
			shot_on     <= 1'b0;
			flash_cnt   <= '0;
			shots_fired <= '0;
			game_state  <= duck_hunt_pkg::state_menu;
			game_start  <= 1'b0;
		end
		else
		begin
			trig_s     <= trigger;
			trig_d     <= trig_s;
			kill_q     <= duck_kill;
			game_start <= 1'b0;

			// flash ends on timeout or release, whichever is first
			if (shot_on)
			begin
				if (flash_cnt == 0 || !trig_s)
					shot_on <= 1'b0;
				else
					flash_cnt <= flash_cnt - 1'b1;
			end

			if (game_state == duck_hunt_pkg::state_menu)
			begin
				if (trig_rise && in_start)
				begin
					game_state <= duck_hunt_pkg::state_play;
					game_start <= 1'b1;
				end
			end
			else if (duck_kill && !kill_q)
				shots_fired <= '0;
			else if (trig_rise && shots_fired < 2'(duck_hunt_pkg::max_shots))
			begin
				shots_fired <= shots_fired + 1'b1;
				shot_on     <= 1'b1;
				flash_cnt   <= cnt_w'(shot_flash_cycles - 1);
			end
		end
	end

endmodule

/* source/duck_sprite_rom.sv */
// duck sprite rom
// packed rows of 4-bit palette indices, two animation frames

`timescale 1ns/1ps

module duck_sprite_rom (
	input  logic                               vga_clk,
	input  logic                               duck_frame,
	input  logic [duck_hunt_pkg::coord_w-1:0] draw_y,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_y,
	output logic [4*duck_hunt_pkg::sprite_px-1:0] row_bits
);

	localparam int row_w = $clog2(duck_hunt_pkg::sprite_px);

	logic [4*duck_hunt_pkg::sprite_px-1:0] rom [2*duck_hunt_pkg::sprite_px];
	logic [duck_hunt_pkg::coord_w-1:0]     dy;
	logic [row_w-1:0]                      row;

	initial
	begin
		$readmemh("include/duck_sprite.mem", rom);
	end

	// rows past the sprite wrap, the mapper masks them anyway
	assign dy  = draw_y - duck_y;
	assign row = row_w'(dy / duck_hunt_pkg::sprite_scale);

	always_ff @(posedge vga_clk)
	begin
		row_bits <= rom[{duck_frame, row}];
	end

endmodule

/* source/duck_palette.sv */
// duck palette
// three 16-entry colour tables and the transparent key

`timescale 1ns/1ps

module duck_palette (
	input  logic [3:0]                 index,
	input  duck_hunt_pkg::duck_color_e duck_color,
	output logic [11:0]                rgb,
	output logic                       transparent
);

	// entry 0 is the key colour and never shown
	localparam logic [11:0] black_tab [16] = '{
		12'h000, 12'h111, 12'h333, 12'h555, 12'hFFF, 12'hF90, 12'hC60, 12'h064,
		12'h0A6, 12'h742, 12'hA86, 12'hDDC, 12'h222, 12'h888, 12'h530, 12'hFD0
	};

	localparam logic [11:0] red_tab [16] = '{
		12'h000, 12'h300, 12'h822, 12'hC33, 12'hFFF, 12'hF90, 12'hC60, 12'hA11,
		12'hE44, 12'h742, 12'hA86, 12'hDDC, 12'h611, 12'h888, 12'h530, 12'hFD0
	};

	localparam logic [11:0] pink_tab [16] = '{
		12'h000, 12'h524, 12'hB69, 12'hE8B, 12'hFFF, 12'hF90, 12'hC60, 12'hD7A,
		12'hFAD, 12'h742, 12'hA86, 12'hDDC, 12'h936, 12'h888, 12'h530, 12'hFD0
	};

	always_comb
	begin
		case (duck_color)
			duck_hunt_pkg::duck_red:  rgb = red_tab[index];
			duck_hunt_pkg::duck_pink: rgb = pink_tab[index];
			// black, and the unused code 3
			default:                  rgb = black_tab[index];
		endcase
	end

	assign transparent = (index == 4'(duck_hunt_pkg::transparent_index));

endmodule

/* source/color_mapper.sv */
// colour mapper
// pixel hit tests for cursor, flash, duck, bullets and start button
// registered priority mux producing the pixel colour

`timescale 1ns/1ps

module color_mapper (
	input  logic                               vga_clk,
	input  logic                               Reset,
	input  logic [duck_hunt_pkg::coord_w-1:0] draw_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] draw_y,
	input  logic                               blank,
	input  logic [duck_hunt_pkg::coord_w-1:0] cursor_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] cursor_y,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_y,
	input  logic                               duck_present,
	input  logic                               shot_on,
	input  logic [1:0]                         shots_fired,
	input  duck_hunt_pkg::game_state_e         game_state,
	input  logic [4*duck_hunt_pkg::sprite_px-1:0] row_bits,
	input  logic [11:0]                        pal_rgb,
	input  logic                               pal_transparent,
	output logic [3:0]                         pal_index,
	output logic [3:0]                         red,
	output logic [3:0]                         green,
	output logic [3:0]                         blue
);

	localparam int col_w = $clog2(duck_hunt_pkg::sprite_px);
	localparam int cw    = duck_hunt_pkg::coord_w;

	logic signed [cw:0]   cur_dx;
	logic signed [cw:0]   cur_dy;
	logic [cw:0]          abs_dx;
	logic [cw:0]          abs_dy;
	logic [cw-1:0]        duck_dx;
	logic [cw-1:0]        duck_dy;
	logic                 cursor_hit;
	logic                 flash_hit;
	logic                 duck_hit;
	logic                 button_hit;
	logic [2:0]           bullet_hit;
	logic                 bullet_lit;
	logic [11:0]          rgb_next;

	// one cycle delay to line up with the rom read
	logic                 blank_d;
	logic                 cursor_d;
	logic                 flash_d;
	logic                 duck_d;
	logic                 button_d;
	logic [2:0]           bullet_d;
	logic [col_w-1:0]     col_d;

	//----------------------------------------------------------------------
	// pixel tests on the current coordinate
	//----------------------------------------------------------------------
	assign cur_dx = $signed({1'b0, draw_x}) - $signed({1'b0, cursor_x});
	assign cur_dy = $signed({1'b0, draw_y}) - $signed({1'b0, cursor_y});
	assign abs_dx = cur_dx[cw] ? -cur_dx : cur_dx;
	assign abs_dy = cur_dy[cw] ? -cur_dy : cur_dy;

	// diamond: |dx| + |dy| within the radius
	assign cursor_hit = (abs_dx + abs_dy) <= duck_hunt_pkg::cursor_size;
	assign flash_hit  = (cur_dx >= -duck_hunt_pkg::flash_half) && (cur_dx <= duck_hunt_pkg::flash_half) &&
		(cur_dy >= -duck_hunt_pkg::flash_half) && (cur_dy <= duck_hunt_pkg::flash_half);

	// offsets left of or above the duck wrap to large values
	assign duck_dx  = draw_x - duck_x;
	assign duck_dy  = draw_y - duck_y;
	assign duck_hit = duck_present && (duck_dx < duck_hunt_pkg::duck_size) &&
		(duck_dy < duck_hunt_pkg::duck_size);

	assign button_hit = (draw_x >= duck_hunt_pkg::start_x0) && (draw_x < duck_hunt_pkg::start_x1) &&
		(draw_y >= duck_hunt_pkg::start_y0) && (draw_y < duck_hunt_pkg::start_y1);

	always_comb
	begin
		for (int i = 0; i < 3; i++)
			bullet_hit[i] = (draw_x >= duck_hunt_pkg::bullet_x0 + i * duck_hunt_pkg::bullet_pitch) &&
				(draw_x < duck_hunt_pkg::bullet_x0 + i * duck_hunt_pkg::bullet_pitch +
				duck_hunt_pkg::bullet_w) && (draw_y >= duck_hunt_pkg::bullet_y0) &&
				(draw_y < duck_hunt_pkg::bullet_y0 + duck_hunt_pkg::bullet_h);
	end

	always_ff @(posedge vga_clk)
	begin
		cursor_d <= cursor_hit;
		flash_d  <= flash_hit;
		duck_d   <= duck_hit;
		button_d <= button_hit;
		bullet_d <= bullet_hit;
		col_d    <= col_w'(duck_dx / duck_hunt_pkg::sprite_scale);
	end

	//----------------------------------------------------------------------
	// sprite nibble and colour priority
	//----------------------------------------------------------------------
	// column 0 sits in the top nibble
	assign pal_index = row_bits[(duck_hunt_pkg::sprite_px - 1 - col_d) * 4 +: 4];

	// rightmost square goes first
	always_comb
	begin
		bullet_lit = 1'b0;
		for (int i = 0; i < 3; i++)
			if (bullet_d[i] && (shots_fired <= 2 - i))
				bullet_lit = 1'b1;
	end

	always_comb
	begin
		if (!blank_d)
			rgb_next = duck_hunt_pkg::black_rgb;
		else if (shot_on)
			rgb_next = flash_d ? duck_hunt_pkg::white_rgb : duck_hunt_pkg::black_rgb;
		else if (cursor_d)
			rgb_next = duck_hunt_pkg::white_rgb;
		else if (duck_d && !pal_transparent)
			rgb_next = pal_rgb;
		else if (game_state == duck_hunt_pkg::state_play)
			rgb_next = bullet_lit ? duck_hunt_pkg::bullet_rgb : duck_hunt_pkg::sky_rgb;
		else
			rgb_next = button_d ? duck_hunt_pkg::button_rgb : duck_hunt_pkg::menu_rgb;
	end

	always_ff @(posedge vga_clk or posedge Reset)
	begin
		if (Reset)
		begin
			blank_d            <= 1'b0;
			{red, green, blue} <= '0;
		end
		else
		begin
			blank_d            <= blank;
			{red, green, blue} <= rgb_next;
		end
	end

endmodule

/* source/duck_hunt_display.sv */
// duck hunt display top level
// vga timing, shot control, sprite rom, palette and colour mapper

`timescale 1ns/1ps

module duck_hunt_display #(
	parameter int shot_flash_cycles = 1_000_000
) (
	input  logic                               vga_clk,
	input  logic                               Reset,
	input  logic [duck_hunt_pkg::coord_w-1:0] cursor_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] cursor_y,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_x,
	input  logic [duck_hunt_pkg::coord_w-1:0] duck_y,
	input  logic                               duck_frame,
	input  duck_hunt_pkg::duck_color_e         duck_color,
	input  logic                               duck_present,
	input  logic                               trigger,
	output logic [3:0]                         red,
	output logic [3:0]                         green,
	output logic [3:0]                         blue,
	output logic                               hsync,
	output logic                               vsync,
	output logic [duck_hunt_pkg::coord_w-1:0] draw_x,
	output logic [duck_hunt_pkg::coord_w-1:0] draw_y,
	output logic [1:0]                         shots_fired,
	output logic                               duck_kill,
	output logic                               game_start
);

	logic                                  blank;
	logic                                  shot_on;
	duck_hunt_pkg::game_state_e            game_state;
	logic [4*duck_hunt_pkg::sprite_px-1:0] row_bits;
	logic [3:0]                            pal_index;
	logic [11:0]                           pal_rgb;
	logic                                  pal_transparent;

	vga_controller u_vga_controller (
		.vga_clk (vga_clk),
		.Reset   (Reset),
		.draw_x  (draw_x),
		.draw_y  (draw_y),
		.blank   (blank),
		.hsync   (hsync),
		.vsync   (vsync)
	);

	shot_control #(
		.shot_flash_cycles (shot_flash_cycles)
	) u_shot_control (
		.vga_clk      (vga_clk),
		.Reset        (Reset),
		.cursor_x     (cursor_x),
		.cursor_y     (cursor_y),
		.duck_x       (duck_x),
		.duck_y       (duck_y),
		.duck_present (duck_present),
		.trigger      (trigger),
		.shot_on      (shot_on),
		.shots_fired  (shots_fired),
		.game_state   (game_state),
		.duck_kill    (duck_kill),
		.game_start   (game_start)
	);

	duck_sprite_rom u_duck_sprite_rom (
		.vga_clk    (vga_clk),
		.duck_frame (duck_frame),
		.draw_y     (draw_y),
		.duck_y     (duck_y),
		.row_bits   (row_bits)
	);

	duck_palette u_duck_palette (
		.index       (pal_index),
		.duck_color  (duck_color),
		.rgb         (pal_rgb),
		.transparent (pal_transparent)
	);

	color_mapper u_color_mapper (
		.vga_clk         (vga_clk),
		.Reset           (Reset),
		.draw_x          (draw_x),
		.draw_y          (draw_y),
		.blank           (blank),
		.cursor_x        (cursor_x),
		.cursor_y        (cursor_y),
		.duck_x          (duck_x),
		.duck_y          (duck_y),
		.duck_present    (duck_present),
		.shot_on         (shot_on),
		.shots_fired     (shots_fired),
		.game_state      (game_state),
		.row_bits        (row_bits),
		.pal_rgb         (pal_rgb),
		.pal_transparent (pal_transparent),
		.pal_index       (pal_index),
		.red             (red),
		.green           (green),
		.blue            (blue)
	);

endmodule

/* dv/tb_duck_hunt.sv */
// testbench for the duck hunt display
// stimulus table, reference pixel model, compare tasks and timeout
// raster position and sync pulses followed every cycle

`timescale 1ns/1ps

module tb_duck_hunt;

	typedef enum {act_probe, act_press, act_flash} action_e;

	typedef struct {
		string   name;
		int      cx, cy, dx, dy;
		logic    frame;
		int      color;
		logic    present;
		action_e act;
		int      px, py;
		logic [1:0] shots;
		logic    pulse;
	} row_t;

	localparam int frame_cycles = duck_hunt_pkg::h_total * duck_hunt_pkg::v_total;

	logic vga_clk;
	logic Reset;
	logic [9:0] cursor_x, cursor_y, duck_x, duck_y;
	logic duck_frame;
	duck_hunt_pkg::duck_color_e duck_color;
	logic duck_present, trigger;
	logic [3:0] red, green, blue;
	logic hsync, vsync;
	logic [9:0] draw_x, draw_y;
	logic [1:0] shots_fired;
	logic duck_kill, game_start;

	row_t rows[$];
	logic [31:0] sprite_mem [16];
	logic [11:0] pal [3][16];
	integer seed;
	int cycles;
	int limit;
	logic model_play;
	logic [1:0] model_shots;

	duck_hunt_display #(
		.shot_flash_cycles (40)
	) u_duck_hunt_display (
		.vga_clk (vga_clk), .Reset (Reset), .cursor_x (cursor_x), .cursor_y (cursor_y),
		.duck_x (duck_x), .duck_y (duck_y), .duck_frame (duck_frame),
		.duck_color (duck_color), .duck_present (duck_present), .trigger (trigger),
		.red (red), .green (green), .blue (blue), .hsync (hsync), .vsync (vsync),
		.draw_x (draw_x), .draw_y (draw_y), .shots_fired (shots_fired),
		.duck_kill (duck_kill), .game_start (game_start)
	);

	initial
	begin
		vga_clk = 1'b0;
		forever #50 vga_clk = ~vga_clk;
	end

	//----------------------------------------------------------------------
	// failure reporting and compare tasks
	//----------------------------------------------------------------------
	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_rgb(input string name, input logic [11:0] exp, input logic [11:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("Error %s expected %h actual %h", name, exp, act));
	endtask

	task automatic check_shots(input string name, input logic [1:0] exp, input logic [1:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("Error %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_state_pulse(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("Error %s expected %b actual %b", name, exp, act));
	endtask

	task automatic check_coord(input string name, input logic [9:0] exp, input logic [9:0] act);
		if (act !== exp)
			stop_with_failure($sformatf("Error %s expected %0d actual %0d", name, exp, act));
	endtask

	task automatic check_sync(input string name, input logic exp, input logic act);
		if (act !== exp)
			stop_with_failure($sformatf("Error %s expected %b actual %b", name, exp, act));
	endtask

	always @(posedge vga_clk)
	begin
		cycles <= cycles + 1;
		if (cycles > limit)
			stop_with_failure("Timeout: the test sequence did not finish in time");
	end

	//----------------------------------------------------------------------
	// raster position and sync pulses
	//----------------------------------------------------------------------
	initial
	begin
		int exp_x;
		int exp_y;
		exp_x = 0;
		exp_y = 0;
		@(negedge Reset);
		forever
		begin
			@(negedge vga_clk);
			check_coord("raster_x", exp_x, draw_x);
			check_coord("raster_y", exp_y, draw_y);
			check_sync("hsync", !(exp_x >= duck_hunt_pkg::h_sync_start &&
				exp_x < duck_hunt_pkg::h_sync_end), hsync);
			check_sync("vsync", !(exp_y >= duck_hunt_pkg::v_sync_start &&
				exp_y < duck_hunt_pkg::v_sync_end), vsync);
			exp_x = exp_x + 1;
			if (exp_x == duck_hunt_pkg::h_total)
			begin
				exp_x = 0;
				exp_y = exp_y + 1;
				if (exp_y == duck_hunt_pkg::v_total)
					exp_y = 0;
			end
		end
	end

	//----------------------------------------------------------------------
	// reference pixel model
	//----------------------------------------------------------------------
	function automatic logic [11:0] model_pixel(input row_t r, input int x, input int y,
		input logic flash);
		int adx, ady, col, row;
		logic [3:0] nib;
		if (x >= duck_hunt_pkg::h_visible || y >= duck_hunt_pkg::v_visible)
			return duck_hunt_pkg::black_rgb;
		adx = (x > r.cx) ? x - r.cx : r.cx - x;
		ady = (y > r.cy) ? y - r.cy : r.cy - y;
		if (flash)
			return (adx <= 25 && ady <= 25) ? duck_hunt_pkg::white_rgb : duck_hunt_pkg::black_rgb;
		if (adx + ady <= 6)
			return duck_hunt_pkg::white_rgb;
		if (r.present && x >= r.dx && x < r.dx + 32 && y >= r.dy && y < r.dy + 32)
		begin
			col = (x - r.dx) / 4;
			row = (y - r.dy) / 4;
			nib = sprite_mem[r.frame * 8 + row][(7 - col) * 4 +: 4];
			if (nib != 0)
				return pal[(r.color == 3) ? 0 : r.color][nib];
		end
		if (model_play)
		begin
			for (int i = 0; i < 3; i++)
				if (x >= 68 + 17 * i && x < 77 + 17 * i && y >= 418 && y < 431 &&
					model_shots <= 2 - i)
					return duck_hunt_pkg::bullet_rgb;
			return duck_hunt_pkg::sky_rgb;
		end
		if (x >= 200 && x < 440 && y >= 200 && y < 250)
			return duck_hunt_pkg::button_rgb;
		return duck_hunt_pkg::menu_rgb;
	endfunction

	//----------------------------------------------------------------------
	// stimulus helpers
	//----------------------------------------------------------------------
	task automatic add_row(input string name, input int cx, input int cy, input int dx,
		input int dy, input logic frame, input int color, input logic present,
		input action_e act, input int px, input int py, input logic [1:0] shots,
		input logic pulse);
		row_t r;
		r = '{name, cx, cy, dx, dy, frame, color, present, act, px, py, shots, pulse};
		rows.push_back(r);
	endtask

	task automatic wait_pixel(input int x, input int y);
		while (!(draw_x == x && draw_y == y))
			@(negedge vga_clk);
	endtask

	task automatic read_pixel(input int x, input int y, output logic [11:0] rgb);
		wait_pixel(x, y);
		@(posedge vga_clk);
		@(posedge vga_clk);
		@(negedge vga_clk);
		rgb = {red, green, blue};
	endtask

	task automatic press_trigger(output int start_cnt, output logic kill_seen);
		start_cnt = 0;
		kill_seen = 1'b0;
		trigger = 1'b1;
		for (int i = 0; i < 70; i++)
		begin
			@(negedge vga_clk);
			if (i == 60)
				trigger = 1'b0;
			start_cnt += game_start;
			kill_seen |= duck_kill;
		end
	endtask

	task automatic run_row(input row_t r);
		logic [11:0] rgb;
		int start_cnt;
		logic kill_seen;
		cursor_x = r.cx;
		cursor_y = r.cy;
		duck_x = r.dx;
		duck_y = r.dy;
		duck_frame = r.frame;
		duck_color = duck_hunt_pkg::duck_color_e'(r.color);
		duck_present = r.present;
		case (r.act)
			act_probe:
			begin
				read_pixel(r.px, r.py, rgb);
				check_rgb(r.name, model_pixel(r, r.px, r.py, 1'b0), rgb);
			end
			act_flash:
			begin
				// press just ahead of the scan so the flash covers the probe
				wait_pixel(r.px - 10, r.py);
				trigger = 1'b1;
				read_pixel(r.px, r.py, rgb);
				check_rgb(r.name, model_pixel(r, r.px, r.py, 1'b1), rgb);
				trigger = 1'b0;
				repeat (10) @(negedge vga_clk);
				check_shots(r.name, r.shots, shots_fired);
			end
			default:
			begin
				press_trigger(start_cnt, kill_seen);
				if (!model_play)
				begin
					check_state_pulse(r.name, r.pulse, logic'(start_cnt != 0));
					if (start_cnt > 1)
						stop_with_failure("game_start stayed high for more than one cycle");
					if (r.pulse)
						model_play = 1'b1;
				end
				else
					check_state_pulse(r.name, r.pulse, kill_seen);
				check_shots(r.name, r.shots, shots_fired);
			end
		endcase
		model_shots = r.shots;
	endtask

	//----------------------------------------------------------------------
	// stimulus table and main sequence
	//----------------------------------------------------------------------
	initial
	begin
		int rx, ry;
		pal[0] = '{12'h000, 12'h111, 12'h333, 12'h555, 12'hFFF, 12'hF90, 12'hC60, 12'h064,
			12'h0A6, 12'h742, 12'hA86, 12'hDDC, 12'h222, 12'h888, 12'h530, 12'hFD0};
		pal[1] = '{12'h000, 12'h300, 12'h822, 12'hC33, 12'hFFF, 12'hF90, 12'hC60, 12'hA11,
			12'hE44, 12'h742, 12'hA86, 12'hDDC, 12'h611, 12'h888, 12'h530, 12'hFD0};
		pal[2] = '{12'h000, 12'h524, 12'hB69, 12'hE8B, 12'hFFF, 12'hF90, 12'hC60, 12'hD7A,
			12'hFAD, 12'h742, 12'hA86, 12'hDDC, 12'h936, 12'h888, 12'h530, 12'hFD0};
		$readmemh("include/duck_sprite.mem", sprite_mem);
		seed = 32'h15cb6cc5;
		Reset = 1'b1;
		trigger = 1'b0;
		cursor_x = '0;
		cursor_y = '0;
		duck_x = '0;
		duck_y = '0;
		duck_frame = 1'b0;
		duck_color = duck_hunt_pkg::duck_black;
		duck_present = 1'b0;
		cycles = 0;
		model_play = 1'b0;
		model_shots = 2'd0;

		// menu screen and game start
		add_row("menu_button", 600, 20, 0, 0, 0, 0, 0, act_probe, 300, 220, 0, 0);
		add_row("menu_bg", 600, 20, 0, 0, 0, 0, 0, act_probe, 10, 10, 0, 0);
		add_row("menu_blank", 600, 20, 0, 0, 0, 0, 0, act_probe, 700, 10, 0, 0);
		add_row("start_outside", 100, 100, 0, 0, 0, 0, 0, act_press, 0, 0, 0, 0);
		add_row("menu_still", 600, 20, 0, 0, 0, 0, 0, act_probe, 10, 10, 0, 0);
		add_row("start_inside", 300, 220, 0, 0, 0, 0, 0, act_press, 0, 0, 0, 1);
		add_row("play_sky", 600, 20, 0, 0, 0, 0, 0, act_probe, 300, 300, 0, 0);
		add_row("bullet_0", 600, 20, 0, 0, 0, 0, 0, act_probe, 70, 420, 0, 0);
		add_row("bullet_1", 600, 20, 0, 0, 0, 0, 0, act_probe, 87, 420, 0, 0);
		add_row("bullet_2", 600, 20, 0, 0, 0, 0, 0, act_probe, 104, 420, 0, 0);

		// random duck positions with probes inside the sprite
		for (int i = 0; i < 6; i++)
		begin
			rx = {$random(seed)} % 600;
			ry = {$random(seed)} % 440;
			add_row($sformatf("sprite_%0d", i), 630, 470, rx, ry, i[0], i % 3, 1, act_probe,
				rx + {$random(seed)} % 32, ry + {$random(seed)} % 32, 0, 0);
		end
		add_row("cursor_over_duck", 310, 310, 300, 300, 0, 1, 1, act_probe, 310, 310, 0, 0);

		// shots, flash and hits
		add_row("flash_in", 320, 240, 0, 0, 0, 0, 0, act_flash, 320, 240, 1, 0);
		add_row("flash_out", 320, 240, 0, 0, 0, 0, 0, act_flash, 350, 240, 2, 0);
		add_row("two_fired_b0", 600, 20, 0, 0, 0, 0, 0, act_probe, 70, 420, 2, 0);
		add_row("two_fired_b1", 600, 20, 0, 0, 0, 0, 0, act_probe, 87, 420, 2, 0);
		add_row("hit_center", 416, 116, 400, 100, 0, 0, 1, act_press, 0, 0, 0, 1);
		add_row("hit_margin", 403, 116, 400, 100, 0, 0, 1, act_press, 0, 0, 1, 0);
		add_row("hit_absent", 416, 116, 400, 100, 0, 0, 0, act_press, 0, 0, 2, 0);
		add_row("third_shot", 600, 20, 0, 0, 0, 0, 0, act_press, 0, 0, 3, 0);
		add_row("fourth_shot", 600, 20, 0, 0, 0, 0, 0, act_press, 0, 0, 3, 0);
		add_row("empty_b0", 600, 20, 0, 0, 0, 0, 0, act_probe, 70, 420, 3, 0);

		// every row waits at most one frame
		limit = (rows.size() + 2) * frame_cycles + 1000;

		repeat (10) @(negedge vga_clk);
		Reset = 1'b0;
		@(negedge vga_clk);
		check_shots("after_reset", 2'd0, shots_fired);
		check_state_pulse("after_reset", 1'b0, game_start);
		check_state_pulse("after_reset", 1'b0, duck_kill);
		check_rgb("after_reset", duck_hunt_pkg::black_rgb, {red, green, blue});

		foreach (rows[i])
			run_row(rows[i]);

		$display("Simulation passed");
		$finish;
	end

endmodule

/* include/duck_sprite.mem */
// duck sprite rows, one 32-bit word per row, 4-bit palette index per cell
// rows 0-7 frame 0, rows 8-15 frame 1, leftmost cell in the top nibble
00022000
0023F200
0223A200
02333350
23333350
02C33300
00222000
00E0E000
00022000
0023F200
2223A200
23333350
02333350
02C33300
00222000
000E0E00

/* tb.f */
source/duck_hunt_pkg.sv
source/vga_controller.sv
source/shot_control.sv
source/duck_sprite_rom.sv
source/duck_palette.sv
source/color_mapper.sv
source/duck_hunt_display.sv
dv/tb_duck_hunt.sv

/* Bender.yml */
package:
  name: duck_hunt_display

sources:
  - files:
      - source/duck_hunt_pkg.sv
      - source/vga_controller.sv
      - source/shot_control.sv
      - source/duck_sprite_rom.sv
      - source/duck_palette.sv
      - source/color_mapper.sv
      - source/duck_hunt_display.sv
  - target: simulation
    files:
      - dv/tb_duck_hunt.sv
